// ==== verif/uart_slave_input.txt ====
# columns: op id word peer status (id, word and status in hex)
# op W write, R read, X bad start code; status is what the next addressed read returns
R 1 12345678 ack 0
W 1 deadbeef ack c
R 1 a5a5f00f ack c
W 1 0badf00d nak a
R 1 87654321 ack a
W 2 11111111 ack a
R 0 22222222 ack a
X 1 33333333 ack a
R 1 0f0f0f0f ack a
W 1 13572468 ack c
W 1 cafe0001 silent a
R 1 fedcba98 ack a
R 3 ffffffff ack a
W 1 89abcdef ack c
R 1 5aa55aa5 ack c
W 1 76543210 silent a
R 1 00000000 ack a
W 1 ffffffff nak a
R 1 ffffffff ack a

// ==== tb.f ====
+incdir+common
common/uart_slave_pkg.sv
source/frame_decoder.sv
source/slave_sequencer.sv
write_channel/write_channel.sv
read_channel/read_channel.sv
source/uart_bus_slave.sv
verif/tb_uart_bus_slave.sv

// ==== verif/tb_uart_bus_slave.sv ====
`timescale 1ns/100ps

`include "uart_slave_config.svh"

module tb_uart_bus_slave import uart_slave_pkg::*; ();

    localparam int FRAME_LEN    = `UART_SLAVE_FRAME_LEN;
    localparam int DATA_W       = `UART_SLAVE_DATA_WIDTH;
    localparam int WAIT_LIMIT   = 200;
    // long enough to see a retransmission after a full ack timeout
    localparam int START_WINDOW = `UART_SLAVE_ACK_TIMEOUT + 24;

    logic         clk;
    logic         rstN;
    logic         control;
    logic         wd;
    logic         valid;
    logic         s_tx_ready;
    logic         g_tx_ready;
    uart_rx_rsp_t s_rx;
    uart_rx_rsp_t g_rx;
    logic         rd;
    logic         ready;
    uart_tx_req_t s_tx;
    uart_tx_req_t g_tx;

    int mismatches;
    int failures;
    bit aborted;

    uart_bus_slave uart_bus_slave_i (.*);

    initial clk = 1'b0;
    always #50 clk = ~clk;

    task automatic note_mismatch(string msg);
        mismatches++;
        $display("MISMATCH at %0t: %s", $time, msg);
    endtask

    task automatic report_failure(string msg);
        failures++;
        $display("ERROR at %0t: %s", $time, msg);
    endtask

    task automatic abort_on_timeout(string what);
        failures++;
        aborted = 1'b1;
        $display("ERROR at %0t: timed out waiting for %s", $time, what);
    endtask

    task automatic compare_word(string what, data_word_t got, data_word_t exp);
        if (got !== exp) begin
            note_mismatch($sformatf("%s got %h expected %h", what, got, exp));
        end
    endtask

    task automatic compare_status(string what, status_nibble_t got, status_nibble_t exp);
        if (got !== exp) begin
            note_mismatch($sformatf("%s got %b expected %b", what, got, exp));
        end
    endtask

    task automatic compare_byte(string what, ack_byte_t got, ack_byte_t exp);
        if (got !== exp) begin
            note_mismatch($sformatf("%s got %b expected %b", what, got, exp));
        end
    endtask

    // start bits, id and r/w bit, msb first
    task automatic send_frame(logic [FRAME_LEN-1:0] bits);
        for (int i = FRAME_LEN - 1; i >= 0; i--) begin
            @(negedge clk);
            control = bits[i];
        end
        @(negedge clk);
        control = 1'b0;
    endtask

    // neither channel may move for a frame the slave should ignore
    task automatic check_silent_bus();
        bit stirred;
        stirred = 1'b0;
        @(negedge clk);
        s_tx_ready = 1'b1;
        g_tx_ready = 1'b1;
        // a get-side word exposes a read frame that was wrongly taken
        g_rx.done  = 1'b1;
        @(negedge clk);
        g_rx.done  = 1'b0;
        repeat (20) begin
            @(posedge clk);
            if (ready || s_tx.start || g_tx.start) begin
                stirred = 1'b1;
            end
        end
        @(negedge clk);
        s_tx_ready = 1'b0;
        g_tx_ready = 1'b0;
        if (stirred) begin
            report_failure("slave reacted to a foreign id or a bad start code");
        end
    endtask

    task automatic run_write(data_word_t word, string peer);
        bit        seen;
        int        starts;
        int        expected;
        ack_byte_t reply;
        seen = 1'b0;
        for (int n = 0; n < WAIT_LIMIT && !seen; n++) begin
            @(posedge clk);
            seen = ready;
        end
        if (!seen) begin
            abort_on_timeout("ready after a write frame");
            return;
        end
        // random valid gaps act as master back-pressure
        for (int i = DATA_W - 1; i >= 0; i--) begin
            repeat ($urandom_range(2)) begin
                @(negedge clk);
                valid = 1'b0;
            end
            @(negedge clk);
            valid = 1'b1;
            wd    = word[i];
        end
        @(negedge clk);
        valid = 1'b0;
        starts = 0;
        do begin
            repeat ($urandom_range(5)) @(negedge clk);
            s_tx_ready = 1'b1;
            seen = 1'b0;
            for (int n = 0; n < START_WINDOW && !seen; n++) begin
                @(posedge clk);
                seen = s_tx.start;
                if (seen) begin
                    starts++;
                    compare_word("s_tx data", s_tx.data, word);
                    if (ready) begin
                        report_failure("ready still high at the send-uart start");
                    end
                end
            end
            @(negedge clk);
            s_tx_ready = 1'b0;
            // the neighbour board answers the first attempt only
            if (seen && starts == 1 && peer != "silent") begin
                reply = (peer == "ack") ? `UART_SLAVE_ACK_CODE : `UART_SLAVE_NAK_CODE;
                repeat ($urandom_range(`UART_SLAVE_ACK_TIMEOUT / 2)) @(negedge clk);
                s_rx.data = data_word_t'(reply);
                s_rx.done = 1'b1;
                @(negedge clk);
                s_rx.done = 1'b0;
            end
        end while (seen && starts <= `UART_SLAVE_RETX_TIMES);
        if (starts == 0) begin
            abort_on_timeout("the send-uart start");
            return;
        end
        expected = (peer == "silent") ? `UART_SLAVE_RETX_TIMES : 1;
        if (starts != expected) begin
            note_mismatch($sformatf("send attempts got %0d expected %0d", starts, expected));
        end
    endtask

    task automatic run_read(data_word_t word, status_nibble_t exp_status);
        bit                seen;
        bit                short_shift;
        logic [DATA_W+3:0] bits;
        repeat (2 + $urandom_range(6)) @(negedge clk);
        g_rx.data = word;
        g_rx.done = 1'b1;
        @(negedge clk);
        g_rx.done = 1'b0;
        repeat ($urandom_range(5)) @(negedge clk);
        g_tx_ready = 1'b1;
        seen = 1'b0;
        for (int n = 0; n < WAIT_LIMIT && !seen; n++) begin
            @(posedge clk);
            seen = g_tx.start;
            if (seen) begin
                compare_byte("g_tx ack byte", g_tx.data[7:0], `UART_SLAVE_ACK_CODE);
                compare_word("g_tx data", g_tx.data, data_word_t'(`UART_SLAVE_ACK_CODE));
            end
        end
        @(negedge clk);
        g_tx_ready = 1'b0;
        if (!seen) begin
            abort_on_timeout("the get-uart ack start");
            return;
        end
        seen = 1'b0;
        for (int n = 0; n < WAIT_LIMIT && !seen; n++) begin
            @(posedge clk);
            seen = ready;
            bits[DATA_W+3] = rd;
        end
        if (!seen) begin
            abort_on_timeout("ready during the read shift");
            return;
        end
        short_shift = 1'b0;
        for (int i = DATA_W + 2; i >= 0; i--) begin
            @(posedge clk);
            short_shift = short_shift || !ready;
            bits[i] = rd;
        end
        @(posedge clk);
        if (short_shift) begin
            report_failure("ready dropped before all read bits were shifted");
        end
        if (ready) begin
            report_failure("ready still high after the read shift");
        end
        compare_status("read status", bits[DATA_W+3 -: 4], exp_status);
        compare_word("read word", bits[DATA_W-1:0], word);
    endtask

    initial begin
        int             fd;
        int             fields;
        string          line;
        string          op;
        string          peer;
        slave_id_t      id;
        data_word_t     word;
        status_nibble_t status;
        logic [2:0]     start_bits;
        void'($urandom(581));
        mismatches = 0;
        failures   = 0;
        aborted    = 1'b0;
        rstN       = 1'b0;
        control    = 1'b0;
        wd         = 1'b0;
        valid      = 1'b0;
        s_tx_ready = 1'b0;
        g_tx_ready = 1'b0;
        s_rx       = '0;
        g_rx       = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        fd = $fopen("verif/uart_slave_input.txt", "r");
        if (fd == 0) begin
            failures++;
            aborted = 1'b1;
            $display("ERROR: cannot open the stimulus file verif/uart_slave_input.txt");
        end
        while (!aborted && !$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            fields = $sscanf(line, "%s %h %h %s %h", op, id, word, peer, status);
            if (fields == 5 && (op == "W" || op == "R" || op == "X")) begin
                // X lines carry a corrupted start code
                start_bits = (op == "X") ? 3'b101 : `UART_SLAVE_START_CODE;
                send_frame({start_bits, id, op == "W"});
                if (op == "X" || id != `UART_SLAVE_ID) begin
                    check_silent_bus();
                end else if (op == "W") begin
                    run_write(word, peer);
                end else begin
                    run_read(word, status);
                end
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== source/uart_bus_slave.sv ====
`timescale 1ns/100ps

module uart_bus_slave import uart_slave_pkg::*; (
    input  logic         clk,
    input  logic         rstN,
    input  logic         control,
    input  logic         wd,
    input  logic         valid,
    input  logic         s_tx_ready,
    input  logic         g_tx_ready,
    input  uart_rx_rsp_t s_rx,
    input  uart_rx_rsp_t g_rx,
    output logic         rd,
    output logic         ready,
    output uart_tx_req_t s_tx,
    output uart_tx_req_t g_tx
);

    logic           listen;
    logic           frame_hit;
    frame_t         frame;
    logic           write_go;
    logic           read_go;
    logic           write_taken;
    logic           write_done;
    logic           read_shift;
    logic           read_done;
    status_nibble_t link_status;

    frame_decoder frame_decoder_i (
        .clk       (clk),
        .rstN      (rstN),
        .listen    (listen),
        .control   (control),
        .frame_hit (frame_hit),
        .frame     (frame)
    );

    slave_sequencer slave_sequencer_i (
        .clk         (clk),
        .rstN        (rstN),
        .frame_hit   (frame_hit),
        .frame       (frame),
        .write_taken (write_taken),
        .write_done  (write_done),
        .read_shift  (read_shift),
        .read_done   (read_done),
        .listen      (listen),
        .write_go    (write_go),
        .read_go     (read_go),
        .ready       (ready)
    );

    // master to send-side uart
    write_channel write_channel_i (
        .clk         (clk),
        .rstN        (rstN),
        .write_go    (write_go),
        .valid       (valid),
        .wd          (wd),
        .s_tx_ready  (s_tx_ready),
        .s_rx        (s_rx),
        .s_tx        (s_tx),
        .write_taken (write_taken),
        .write_done  (write_done),
        .link_status (link_status)
    );

    // get-side uart to master
    read_channel read_channel_i (
        .clk         (clk),
        .rstN        (rstN),
        .read_go     (read_go),
        .g_rx        (g_rx),
        .g_tx_ready  (g_tx_ready),
        .link_status (link_status),
        .g_tx        (g_tx),
        .rd          (rd),
        .read_shift  (read_shift),
        .read_done   (read_done)
    );

endmodule

// ==== read_channel/read_channel.sv ====
`timescale 1ns/100ps

`include "uart_slave_config.svh"

module read_channel import uart_slave_pkg::*; (
    input  logic           clk,
    input  logic           rstN,
    input  logic           read_go,
    input  uart_rx_rsp_t   g_rx,
    input  logic           g_tx_ready,
    input  status_nibble_t link_status,
    output uart_tx_req_t   g_tx,
    output logic           rd,
    output logic           read_shift,
    output logic           read_done
);

    localparam int DATA_W    = `UART_SLAVE_DATA_WIDTH;
    localparam int STAT_W    = $bits(status_nibble_t);
    localparam int SHIFT_LEN = STAT_W + DATA_W;
    localparam int CNT_W     = $clog2(SHIFT_LEN);

    localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(SHIFT_LEN - 1);

    typedef enum logic [1:0] {
        R_IDLE,
        R_WAIT_RX,
        R_ACK,
        R_SHIFT
    } rd_state_t;

    rd_state_t            state;
    logic [CNT_W-1:0]     bit_cnt;
    logic [SHIFT_LEN-1:0] out_sr;
    logic                 ack_send;

    // ack byte back to the previous board once the word is held
    assign ack_send   = (state == R_ACK) && g_tx_ready;
    assign g_tx.start = ack_send;
    assign g_tx.data  = byte_word(`UART_SLAVE_ACK_CODE);

    assign read_shift = (state == R_SHIFT);
    assign rd         = read_shift ? out_sr[SHIFT_LEN-1] : 1'b0;

    // status nibble on top of the word, shifted out msb first
    always_ff @(posedge clk) begin
        if ((state == R_WAIT_RX) && g_rx.done) begin
            out_sr[DATA_W-1:0] <= g_rx.data;
        end else if (ack_send) begin
            out_sr[SHIFT_LEN-1 -: STAT_W] <= link_status;
        end else if (read_shift) begin
            out_sr <= {out_sr[SHIFT_LEN-2:0], 1'b0};
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state     <= R_IDLE;
            bit_cnt   <= '0;
            read_done <= 1'b0;
        end else begin
            read_done <= 1'b0;
            case (state)
                R_IDLE: begin
                    if (read_go) begin
                        state <= R_WAIT_RX;
                    end
                end
                R_WAIT_RX: begin
                    if (g_rx.done) begin
                        state <= R_ACK;
                    end
                end
                R_ACK: begin
                    if (ack_send) begin
                        state   <= R_SHIFT;
                        bit_cnt <= '0;
                    end
                end
                R_SHIFT: begin
                    // master cannot stall, one bit every cycle
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == LAST_BIT) begin
                        state     <= R_IDLE;
                        read_done <= 1'b1;
                    end
                end
                default: begin
                    state <= R_IDLE;
                end
            endcase
        end
    end

    // a new read only arrives once the previous shift is over
    a_go_when_idle : assert property (@(posedge clk) disable iff (!rstN)
        read_go |-> (state == R_IDLE))
        else $error("read started while the read channel was busy");

endmodule

// ==== write_channel/write_channel.sv ====
`timescale 1ns/100ps

`include "uart_slave_config.svh"

module write_channel import uart_slave_pkg::*; (
    input  logic           clk,
    input  logic           rstN,
    input  logic           write_go,
    input  logic           valid,
    input  logic           wd,
    input  logic           s_tx_ready,
    input  uart_rx_rsp_t   s_rx,
    output uart_tx_req_t   s_tx,
    output logic           write_taken,
    output logic           write_done,
    output status_nibble_t link_status
);

    localparam int DATA_W  = `UART_SLAVE_DATA_WIDTH;
    localparam int BIT_W   = $clog2(DATA_W);
    localparam int TIMER_W = $clog2(`UART_SLAVE_ACK_TIMEOUT);
    localparam int TRY_W   = $clog2(`UART_SLAVE_RETX_TIMES + 1);

    localparam logic [BIT_W-1:0]   LAST_BIT  = BIT_W'(DATA_W - 1);
    localparam logic [TIMER_W-1:0] LAST_TICK = TIMER_W'(`UART_SLAVE_ACK_TIMEOUT - 1);
    localparam logic [TRY_W-1:0]   MAX_TRIES = TRY_W'(`UART_SLAVE_RETX_TIMES);

    typedef enum logic [1:0] {
        W_IDLE,
        W_RECV,
        W_LAUNCH,
        W_WAIT
    } wr_state_t;

    wr_state_t          state;
    logic [BIT_W-1:0]   bit_cnt;
    logic [TIMER_W-1:0] ack_timer;
    logic [TRY_W-1:0]   tries;
    data_word_t         word_sr;
    logic               launch;

    // start only goes out while the transmitter can take it
    assign launch     = (state == W_LAUNCH) && s_tx_ready;
    assign s_tx.start = launch;
    assign s_tx.data  = word_sr;

    // msb first, paused whenever valid is low
    always_ff @(posedge clk) begin
        if ((state == W_RECV) && valid) begin
            word_sr <= {word_sr[DATA_W-2:0], wd};
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state       <= W_IDLE;
            bit_cnt     <= '0;
            ack_timer   <= '0;
            tries       <= '0;
            write_taken <= 1'b0;
            write_done  <= 1'b0;
            link_status <= '0;
        end else begin
            write_taken <= 1'b0;
            write_done  <= 1'b0;
            case (state)
                W_IDLE: begin
                    if (write_go) begin
                        state   <= W_RECV;
                        bit_cnt <= '0;
                    end
                end
                W_RECV: begin
                    if (valid) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == LAST_BIT) begin
                            state       <= W_LAUNCH;
                            tries       <= '0;
                            write_taken <= 1'b1;
                        end
                    end
                end
                W_LAUNCH: begin
                    if (launch) begin
                        state     <= W_WAIT;
                        ack_timer <= '0;
                        tries     <= tries + 1'b1;
                    end
                end
                W_WAIT: begin
                    if (s_rx.done) begin
                        // anything other than the ack byte counts as nak
                        if (s_rx.data == byte_word(`UART_SLAVE_ACK_CODE)) begin
                            link_status <= status_of(`UART_SLAVE_ACK_CODE);
                        end else begin
                            link_status <= status_of(`UART_SLAVE_NAK_CODE);
                        end
                        write_done <= 1'b1;
                        state      <= W_IDLE;
                    end else if (ack_timer == LAST_TICK) begin
                        if (tries == MAX_TRIES) begin
                            // link silent on every attempt
                            link_status <= status_of(`UART_SLAVE_NAK_CODE);
                            write_done  <= 1'b1;
                            state       <= W_IDLE;
                        end else begin
                            state <= W_LAUNCH;
                        end
                    end else begin
                        ack_timer <= ack_timer + 1'b1;
                    end
                end
                default: begin
                    state <= W_IDLE;
                end
            endcase
        end
    end

    // never more send attempts than the retransmit budget
    a_tx_tries_limit : assert property (@(posedge clk) disable iff (!rstN)
        s_tx.start |-> (tries < MAX_TRIES))
        else $error("send uart started beyond the attempt limit");

endmodule

// ==== source/slave_sequencer.sv ====
`timescale 1ns/100ps

module slave_sequencer import uart_slave_pkg::*; (
    input  logic   clk,
    input  logic   rstN,
    input  logic   frame_hit,
    input  frame_t frame,
    input  logic   write_taken,
    input  logic   write_done,
    input  logic   read_shift,
    input  logic   read_done,
    output logic   listen,
    output logic   write_go,
    output logic   read_go,
    output logic   ready
);

    seq_state_t state;
    seq_state_t state_next;

    // only an idle slave looks at the control line
    assign listen   = (state == IDLE);
    assign write_go = listen && frame_hit && frame.rw;
    assign read_go  = listen && frame_hit && !frame.rw;

    // ready drops together with write_taken after the last data bit
    assign ready = ((state == WRITE_DATA) && !write_taken) || read_shift;

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (write_go) begin
                    state_next = WRITE_DATA;
                end else if (read_go) begin
                    state_next = READ;
                end
            end
            WRITE_DATA: begin
                if (write_taken) begin
                    state_next = WRITE_WAIT;
                end
            end
            WRITE_WAIT: begin
                // uart send and ack handling run in the write channel
                if (write_done) begin
                    state_next = IDLE;
                end
            end
            READ: begin
                if (read_done) begin
                    state_next = IDLE;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // the read channel only shifts while the bus is held for a read
    a_shift_in_read : assert property (@(posedge clk) disable iff (!rstN)
        read_shift |-> (state == READ))
        else $error("read shift outside the read state");

endmodule

// ==== source/frame_decoder.sv ====
`timescale 1ns/100ps

`include "uart_slave_config.svh"

module frame_decoder import uart_slave_pkg::*; (
    input  logic   clk,
    input  logic   rstN,
    input  logic   listen,
    input  logic   control,
    output logic   frame_hit,
    output frame_t frame
);

    localparam int FRAME_LEN = `UART_SLAVE_FRAME_LEN;
    localparam int CNT_W = $clog2(FRAME_LEN);
    localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(FRAME_LEN - 1);

    logic [CNT_W-1:0]     bit_cnt;
    logic [FRAME_LEN-1:0] frame_sr;
    logic [FRAME_LEN-1:0] incoming;
    logic                 shift_en;
    logic                 start_ok;
    logic                 id_ok;

    // first start bit opens a frame, then every cycle is one bit
    assign shift_en = (bit_cnt != '0) || (listen && control);
    assign incoming = {frame_sr[FRAME_LEN-2:0], control};

    assign start_ok = (incoming[FRAME_LEN-1 -: 3] == `UART_SLAVE_START_CODE);
    assign id_ok    = (incoming[`UART_SLAVE_ID_WIDTH:1] == slave_id_t'(`UART_SLAVE_ID));

    always_ff @(posedge clk) begin
        if (shift_en) begin
            frame_sr <= incoming;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            bit_cnt   <= '0;
            frame_hit <= 1'b0;
        end else begin
            frame_hit <= 1'b0;
            if (bit_cnt == '0) begin
                if (listen && control) begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end else if (bit_cnt == LAST_BIT) begin
                // wrong start code or foreign id goes back to waiting
                bit_cnt   <= '0;
                frame_hit <= start_ok && id_ok;
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    // fields stay in the shift register while frame_hit is high
    assign frame.rw = frame_sr[0];
    assign frame.id = frame_sr[`UART_SLAVE_ID_WIDTH:1];

    a_hit_single : assert property (@(posedge clk) disable iff (!rstN)
        frame_hit |=> !frame_hit)
        else $error("frame_hit held for more than one cycle");

endmodule

// ==== common/uart_slave_pkg.sv ====
`include "uart_slave_config.svh"

package uart_slave_pkg;

    // one word moved between master and uart links
    typedef logic [`UART_SLAVE_DATA_WIDTH-1:0] data_word_t;

    // address field of a control frame
    typedef logic [`UART_SLAVE_ID_WIDTH-1:0] slave_id_t;

    // ack or nak byte on the uart links
    typedef logic [7:0] ack_byte_t;

    // upper half of the last ack/nak byte, 0000 until the first write ends
    typedef logic [3:0] status_nibble_t;

    // decoded control frame
    typedef struct packed {
        logic      rw;
        slave_id_t id;
    } frame_t;

    // request toward a uart transmitter
    typedef struct packed {
        logic       start;
        data_word_t data;
    } uart_tx_req_t;

    // response from a uart receiver, data valid with done
    typedef struct packed {
        logic       done;
        data_word_t data;
    } uart_rx_rsp_t;

    // top level bus states
    typedef enum logic [1:0] {
        IDLE,
        WRITE_DATA,
        WRITE_WAIT,
        READ
    } seq_state_t;

    // status reported to the master for a given ack byte
    function automatic status_nibble_t status_of(ack_byte_t code);
        return code[7:4];
    endfunction

    // byte payloads sit in the low bits of a uart word
    function automatic data_word_t byte_word(ack_byte_t code);
        return data_word_t'(code);
    endfunction

endpackage

// ==== common/uart_slave_config.svh ====
`ifndef UART_SLAVE_CONFIG_SVH
`define UART_SLAVE_CONFIG_SVH

// width of one data word on wd, rd and both uart links
`define UART_SLAVE_DATA_WIDTH 32

// slave address field in the control frame
`define UART_SLAVE_ID_WIDTH 2
`define UART_SLAVE_ID 2'd1

// leading bits of every control frame
`define UART_SLAVE_START_CODE 3'b111

// acknowledgement bytes exchanged with the neighbour boards
`define UART_SLAVE_ACK_CODE 8'b11001100
`define UART_SLAVE_NAK_CODE 8'b10101010

// cycles to wait for an ack after each send attempt
`define UART_SLAVE_ACK_TIMEOUT 64
// total send attempts before giving up
`define UART_SLAVE_RETX_TIMES 3

// start bits + slave id + r/w bit
`define UART_SLAVE_FRAME_LEN (3 + `UART_SLAVE_ID_WIDTH + 1)

`endif
